//--- Bender.yml
package:
  name: pc_path

dependencies: {}

sources:
  # packages first, the RTL depends on them
  - common/rv_isa_pkg.sv
  - common/pc_ctrl_pkg.sv

  # next-PC path RTL
  - hdl/branch_decode.sv
  - next_pc/branch_compare.sv
  - next_pc/next_pc_select.sv
  - hdl/pc_sequencer.sv
  - hdl/pc_path_top.sv

  # testbench
  - target: simulation
    files:
      - verification/tb_pc_path.sv

//--- common/pc_ctrl_pkg.sv
package pc_ctrl_pkg;

   // condition handed from decoder to comparator
   typedef enum logic [2:0] {
      br_none = 3'd0,
      br_eq   = 3'd1,
      br_ne   = 3'd2,
      br_lt   = 3'd3,
      br_ge   = 3'd4,
      br_ltu  = 3'd5,
      br_geu  = 3'd6
   } br_cond_e;

   localparam int unsigned pc_step = 4; // no compressed instructions

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int xlen = 64;
   localparam int ilen = 32;

   // major opcodes used by the next-PC path
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_system = 7'b1110011;

   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   localparam logic [ilen-1:0] ebreak_word = 32'h0010_0073;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // one fetched word, viewed per format
   typedef union packed {
      b_fmt_t          b;
      j_fmt_t          j;
      i_fmt_t          i;
      logic [ilen-1:0] raw;
   } rv_instr_u;

endpackage

//--- hdl/branch_decode.sv
`timescale 1ns/10ps

module branch_decode (
   input  rv_isa_pkg::rv_instr_u       instr,
   output pc_ctrl_pkg::br_cond_e       br_cond,
   output logic                        is_branch,
   output logic                        is_jal,
   output logic                        is_jalr,
   output logic                        is_ebreak,
   output logic [rv_isa_pkg::xlen-1:0] imm
);

   import rv_isa_pkg::*;
   import pc_ctrl_pkg::*;

   logic [12:0]     b_imm;
   logic [20:0]     j_imm;
   logic [11:0]     i_imm;
   logic [xlen-1:0] b_imm_ext;
   logic [xlen-1:0] j_imm_ext;
   logic [xlen-1:0] i_imm_ext;

   // scattered immediate bits back in order
   assign b_imm = {instr.b.imm_12,
                   instr.b.imm_11,
                   instr.b.imm_10_5,
                   instr.b.imm_4_1,
                   1'b0};

   assign j_imm = {instr.j.imm_20,
                   instr.j.imm_19_12,
                   instr.j.imm_11,
                   instr.j.imm_10_1,
                   1'b0};

   assign i_imm = instr.i.imm;

   assign b_imm_ext = {{(xlen-13){b_imm[12]}}, b_imm};
   assign j_imm_ext = {{(xlen-21){j_imm[20]}}, j_imm};
   assign i_imm_ext = {{(xlen-12){i_imm[11]}}, i_imm};

   always_comb begin
      br_cond   = br_none;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_ebreak = 1'b0;
      imm       = '0;

      case (instr.i.opcode)
         opc_branch: begin
            imm = b_imm_ext;
            case (instr.b.funct3)
               f3_beq:  br_cond = br_eq;
               f3_bne:  br_cond = br_ne;
               f3_blt:  br_cond = br_lt;
               f3_bge:  br_cond = br_ge;
               f3_bltu: br_cond = br_ltu;
               f3_bgeu: br_cond = br_geu;
               default: br_cond = br_none; // 010, 011 reserved
            endcase
            is_branch = (br_cond != br_none);
         end

         opc_jal: begin
            is_jal = 1'b1;
            imm    = j_imm_ext;
         end

         opc_jalr: begin
            is_jalr = 1'b1;
            imm     = i_imm_ext;
         end

         opc_system: begin
            // ecall/csr share this opcode, only the exact word counts
            is_ebreak = (instr.raw == ebreak_word);
            imm       = i_imm_ext;
         end

         default: begin
            imm = '0;
         end
      endcase
   end

endmodule

//--- hdl/pc_path_top.sv
`timescale 1ns/10ps

module pc_path_top #(
   parameter logic [rv_isa_pkg::xlen-1:0] reset_vector = 64'h8000_0000,
   parameter logic [rv_isa_pkg::xlen-1:0] trap_vector  = 64'h8000_0000
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ena,
   input  logic [rv_isa_pkg::ilen-1:0] instr,
   input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
   input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
   output logic [rv_isa_pkg::xlen-1:0] pc,
   output logic                        redirect
);

   import rv_isa_pkg::*;
   import pc_ctrl_pkg::*;

   br_cond_e        br_cond;
   logic            is_branch;
   logic            is_jal;
   logic            is_jalr;
   logic            is_ebreak;
   logic [xlen-1:0] imm;
   logic            taken;
   logic [xlen-1:0] next_pc;
   logic            non_seq;

   branch_decode u_decode (
      .instr     (instr),
      .br_cond   (br_cond),
      .is_branch (is_branch),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .is_ebreak (is_ebreak),
      .imm       (imm)
   );

   branch_compare u_compare (
      .br_cond  (br_cond),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .taken    (taken)
   );

   next_pc_select #(
      .trap_vector (trap_vector)
   ) u_select (
      .pc        (pc),
      .imm       (imm),
      .rs1_data  (rs1_data),
      .is_branch (is_branch),
      .taken     (taken),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .is_ebreak (is_ebreak),
      .next_pc   (next_pc),
      .non_seq   (non_seq)
   );

   pc_sequencer #(
      .reset_vector (reset_vector)
   ) u_sequencer (
      .clk      (clk),
      .rst      (rst),
      .ena      (ena),
      .next_pc  (next_pc),
      .non_seq  (non_seq),
      .pc       (pc),
      .redirect (redirect)
   );

endmodule

//--- hdl/pc_sequencer.sv
`timescale 1ns/10ps

module pc_sequencer #(
   parameter logic [rv_isa_pkg::xlen-1:0] reset_vector = 64'h8000_0000
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ena,
   input  logic [rv_isa_pkg::xlen-1:0] next_pc,
   input  logic                        non_seq,
   output logic [rv_isa_pkg::xlen-1:0] pc,
   output logic                        redirect
);

   // architectural pc, holds while stalled
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= reset_vector;
      end
      else if (ena) begin
         pc <= next_pc;
      end
   end

   // one pulse per taken redirect so fetch can drop its prefetched word
   always_ff @(posedge clk) begin
      if (rst) begin
         redirect <= 1'b0;
      end
      else if (ena) begin
         redirect <= non_seq;
      end
      else begin
         redirect <= 1'b0; // no pulse on a stall
      end
   end

endmodule

//--- next_pc/branch_compare.sv
`timescale 1ns/10ps

module branch_compare (
   input  pc_ctrl_pkg::br_cond_e       br_cond,
   input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
   input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
   output logic                        taken
);

   import pc_ctrl_pkg::*;

   logic eq;
   logic lt;
   logic ltu;

   assign eq  = (rs1_data == rs2_data);
   assign lt  = ($signed(rs1_data) < $signed(rs2_data));
   assign ltu = (rs1_data < rs2_data);

   always_comb begin
      case (br_cond)
         br_eq:   taken = eq;
         br_ne:   taken = ~eq;
         br_lt:   taken = lt;
         br_ge:   taken = ~lt;  // ge is not lt
         br_ltu:  taken = ltu;
         br_geu:  taken = ~ltu;
         default: taken = 1'b0; // br_none
      endcase
   end

endmodule

//--- next_pc/next_pc_select.sv
`timescale 1ns/10ps

module next_pc_select #(
   parameter logic [rv_isa_pkg::xlen-1:0] trap_vector = 64'h8000_0000
) (
   input  logic [rv_isa_pkg::xlen-1:0] pc,
   input  logic [rv_isa_pkg::xlen-1:0] imm,
   input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
   input  logic                        is_branch,
   input  logic                        taken,
   input  logic                        is_jal,
   input  logic                        is_jalr,
   input  logic                        is_ebreak,
   output logic [rv_isa_pkg::xlen-1:0] next_pc,
   output logic                        non_seq
);

   import rv_isa_pkg::*;
   import pc_ctrl_pkg::*;

   logic [xlen-1:0] seq_pc;
   logic [xlen-1:0] rel_pc;
   logic [xlen-1:0] jalr_sum;
   logic [xlen-1:0] jalr_pc;

   assign seq_pc   = pc + xlen'(pc_step);
   assign rel_pc   = pc + imm;  // branch and jal share the adder
   assign jalr_sum = rs1_data + imm;
   assign jalr_pc  = {jalr_sum[xlen-1:1], 1'b0};

   always_comb begin
      if (is_branch && taken) begin
         next_pc = rel_pc;
         non_seq = 1'b1;
      end
      else if (is_branch) begin
         next_pc = seq_pc; // fall through
         non_seq = 1'b0;
      end
      else if (is_jal) begin
         next_pc = rel_pc;
         non_seq = 1'b1;
      end
      else if (is_jalr) begin
         next_pc = jalr_pc;
         non_seq = 1'b1;
      end
      else if (is_ebreak) begin
         next_pc = trap_vector;
         non_seq = 1'b1;
      end
      else begin
         next_pc = seq_pc;
         non_seq = 1'b0;
      end
   end

endmodule

//--- pc_path.f
common/rv_isa_pkg.sv
common/pc_ctrl_pkg.sv
hdl/branch_decode.sv
next_pc/branch_compare.sv
next_pc/next_pc_select.sv
hdl/pc_sequencer.sv
hdl/pc_path_top.sv
verification/tb_pc_path.sv

//--- verification/tb_pc_path.sv
`timescale 1ns/10ps

module tb_pc_path;

   import rv_isa_pkg::*;
   import pc_ctrl_pkg::*;

   localparam int              clk_period   = 40;
   localparam int              reset_cycles = 10;
   localparam logic [xlen-1:0] reset_vec    = 64'h0000_0000_8000_0000;
   localparam logic [xlen-1:0] trap_vec     = 64'h0000_0000_8000_1000;
   localparam logic [6:0]      opc_op_imm   = 7'b0010011; // addi and friends

   localparam int kind_seq    = 0;
   localparam int kind_branch = 1;
   localparam int kind_jal    = 2;
   localparam int kind_jalr   = 3;
   localparam int kind_ebreak = 4;

   logic            clk;
   logic            rst;
   logic            ena;
   logic [ilen-1:0] instr;
   logic [xlen-1:0] rs1_data;
   logic [xlen-1:0] rs2_data;
   logic [xlen-1:0] pc;
   logic            redirect;

   logic [31:0] lfsr_state;
   bit          table_ready;

   // stimulus columns followed by expected columns
   string           name_q[$];
   bit              ena_q[$];
   int              kind_q[$];
   br_cond_e        cond_q[$];
   logic [ilen-1:0] instr_q[$];
   logic [xlen-1:0] imm_q[$];
   logic [xlen-1:0] rs1_q[$];
   logic [xlen-1:0] rs2_q[$];
   logic [xlen-1:0] exp_pc_q[$];
   bit              exp_redirect_q[$];

   pc_path_top #(
      .reset_vector (reset_vec),
      .trap_vector  (trap_vec)
   ) u_dut (
      .clk      (clk),
      .rst      (rst),
      .ena      (ena),
      .instr    (instr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .pc       (pc),
      .redirect (redirect)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic lfsr_step();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [xlen-1:0] rand_bits(input int nbits);
      logic [xlen-1:0] v;
      int              k;
      v = '0;
      for (k = 0; k < nbits; k++) begin
         v = {v[xlen-2:0], lfsr_step()};
      end
      return v;
   endfunction

   function automatic logic [ilen-1:0] b_word(input logic [2:0] f3, input int off);
      rv_instr_u   w;
      logic [12:0] o;
      o            = off[12:0];
      w.raw        = '0;
      w.b.opcode   = opc_branch;
      w.b.funct3   = f3;
      w.b.rs1      = 5'd10;
      w.b.rs2      = 5'd11;
      w.b.imm_12   = o[12];
      w.b.imm_11   = o[11];
      w.b.imm_10_5 = o[10:5];
      w.b.imm_4_1  = o[4:1];
      return w.raw;
   endfunction

   function automatic logic [ilen-1:0] j_word(input int off);
      rv_instr_u   w;
      logic [20:0] o;
      o             = off[20:0];
      w.raw         = '0;
      w.j.opcode    = opc_jal;
      w.j.rd        = 5'd1;
      w.j.imm_20    = o[20];
      w.j.imm_19_12 = o[19:12];
      w.j.imm_11    = o[11];
      w.j.imm_10_1  = o[10:1];
      return w.raw;
   endfunction

   function automatic logic [ilen-1:0] i_word(input logic [6:0] opcode,
                                              input logic [2:0] f3, input int off);
      rv_instr_u w;
      w.raw      = '0;
      w.i.opcode = opcode;
      w.i.funct3 = f3;
      w.i.imm    = off[11:0];
      w.i.rs1    = (opcode == opc_system) ? 5'd0 : 5'd5;
      w.i.rd     = (opcode == opc_system) ? 5'd0 : 5'd6;
      return w.raw;
   endfunction

   function automatic bit branch_taken(input br_cond_e c, input logic [xlen-1:0] a,
                                       input logic [xlen-1:0] b);
      case (c)
         br_eq:   return a == b;
         br_ne:   return a != b;
         br_lt:   return $signed(a) < $signed(b);
         br_ge:   return $signed(a) >= $signed(b);
         br_ltu:  return a < b;
         br_geu:  return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   task automatic push_row(input string name, input bit en, input int kind,
                           input br_cond_e cond, input logic [ilen-1:0] word,
                           input int off, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b);
      name_q.push_back(name);
      ena_q.push_back(en);
      kind_q.push_back(kind);
      cond_q.push_back(cond);
      instr_q.push_back(word);
      imm_q.push_back(longint'(off)); // sign extended offset
      rs1_q.push_back(a);
      rs2_q.push_back(b);
   endtask

   task automatic seq_row(input string name, input bit en, input logic [ilen-1:0] word);
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      a = rand_bits(xlen);
      b = rand_bits(xlen);
      push_row(name, en, kind_seq, br_none, word, 0, a, b);
   endtask

   task automatic branch_row(input string name, input logic [2:0] f3, input br_cond_e cond,
                             input int off, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b);
      // reserved funct3 is not a branch at all
      push_row(name, 1'b1, (cond == br_none) ? kind_seq : kind_branch, cond,
               b_word(f3, off), off, a, b);
   endtask

   task automatic jump_row(input string name, input bit link_reg, input int off);
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      a = rand_bits(xlen);
      b = rand_bits(xlen);
      a[0] = 1'b0; // even base so an odd offset leaves bit 0 for jalr to clear
      if (link_reg) begin
         push_row(name, 1'b1, kind_jalr, br_none, i_word(opc_jalr, 3'b000, off), off, a, b);
      end
      else begin
         push_row(name, 1'b1, kind_jal, br_none, j_word(off), off, a, b);
      end
   endtask

   task automatic build_table();
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic [xlen-1:0] neg;
      logic [xlen-1:0] pos;
      seq_row("addi_first", 1'b1, i_word(opc_op_imm, 3'b000, 1));
      seq_row("addi_second", 1'b1, i_word(opc_op_imm, 3'b000, -7));
      push_row("stall_jal", 1'b0, kind_jal, br_none, j_word(64), 64, '0, '0);
      seq_row("stall_addi", 1'b0, i_word(opc_op_imm, 3'b000, 3));
      seq_row("addi_after_stall", 1'b1, i_word(opc_op_imm, 3'b000, 9));
      a = rand_bits(xlen);
      b = rand_bits(xlen);
      neg = rand_bits(xlen);
      neg[xlen-1] = 1'b1;
      pos = rand_bits(xlen);
      pos[xlen-1] = 1'b0;
      branch_row("beq_equal", f3_beq, br_eq, 16, a, a);
      branch_row("beq_random", f3_beq, br_eq, 20, a, b);
      branch_row("bne_random", f3_bne, br_ne, -8, a, b);
      branch_row("bne_equal", f3_bne, br_ne, 40, b, b);
      branch_row("blt_neg_pos", f3_blt, br_lt, 32, neg, pos);
      branch_row("bltu_neg_pos", f3_bltu, br_ltu, 32, neg, pos);
      branch_row("bge_pos_neg", f3_bge, br_ge, -64, pos, neg);
      branch_row("bgeu_pos_neg", f3_bgeu, br_geu, 128, pos, neg);
      branch_row("bltu_pos_neg", f3_bltu, br_ltu, -48, pos, neg);
      branch_row("bge_neg_pos", f3_bge, br_ge, 60, neg, pos);
      branch_row("bge_equal", f3_bge, br_ge, 12, neg, neg);
      branch_row("blt_equal", f3_blt, br_lt, 36, neg, neg);
      branch_row("bltu_equal", f3_bltu, br_ltu, 24, pos, pos);
      branch_row("bgeu_equal", f3_bgeu, br_geu, -28, pos, pos);
      branch_row("blt_random", f3_blt, br_lt, 44, b, a);
      branch_row("bge_random", f3_bge, br_ge, 8, a, b);
      branch_row("bltu_random", f3_bltu, br_ltu, -36, a, b);
      branch_row("bgeu_random", f3_bgeu, br_geu, 52, b, a);
      branch_row("beq_far_back", f3_beq, br_eq, -4096, b, b);
      jump_row("jal_forward", 1'b0, 2048);
      jump_row("jal_backward", 1'b0, -1024);
      jump_row("jalr_neg_imm", 1'b1, -3);
      jump_row("jalr_pos_imm", 1'b1, 5);
      push_row("ebreak", 1'b1, kind_ebreak, br_none, i_word(opc_system, 3'b000, 1), 1, a, b);
      push_row("stall_ebreak", 1'b0, kind_ebreak, br_none, ebreak_word, 1, a, b);
      seq_row("addi_at_trap", 1'b1, i_word(opc_op_imm, 3'b000, 2));
      branch_row("branch_f3_010", 3'b010, br_none, 16, a, a);
      branch_row("branch_f3_011", 3'b011, br_none, -16, b, b);
      seq_row("ecall", 1'b1, i_word(opc_system, 3'b000, 0));
      seq_row("addi_last", 1'b1, i_word(opc_op_imm, 3'b000, 4));
   endtask

   // walk the table with a model pc
   task automatic fill_expected();
      logic [xlen-1:0] mpc;
      logic [xlen-1:0] npc;
      bit              jump;
      int              i;
      mpc = reset_vec;
      for (i = 0; i < name_q.size(); i++) begin
         jump = 1'b1;
         if (kind_q[i] == kind_branch && branch_taken(cond_q[i], rs1_q[i], rs2_q[i])) begin
            npc = mpc + imm_q[i];
         end
         else if (kind_q[i] == kind_jal) begin
            npc = mpc + imm_q[i];
         end
         else if (kind_q[i] == kind_jalr) begin
            npc = (rs1_q[i] + imm_q[i]) & ~xlen'(1);
         end
         else if (kind_q[i] == kind_ebreak) begin
            npc = trap_vec;
         end
         else begin
            npc  = mpc + xlen'(pc_step);
            jump = 1'b0;
         end
         if (ena_q[i]) begin
            mpc = npc;
            exp_redirect_q.push_back(jump);
         end
         else begin
            exp_redirect_q.push_back(1'b0);
         end
         exp_pc_q.push_back(mpc);
      end
   endtask

   task automatic check_value(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
      if (actual !== expected) begin
         $display("mismatch %s expected %h actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "stopped at the first error");
      end
   endtask

   initial begin
      int i;
      lfsr_state  = 32'hcdee97c4;
      table_ready = 1'b0;
      rst         = 1'b1;
      ena         = 1'b0;
      instr       = '0;
      rs1_data    = '0;
      rs2_data    = '0;
      build_table();
      fill_expected();
      table_ready = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("reset pc", reset_vec, pc);
      check_value("reset redirect", '0, redirect);
      for (i = 0; i <= name_q.size(); i++) begin
         @(posedge clk);
         if (i < name_q.size()) begin
            ena      <= ena_q[i];
            instr    <= instr_q[i];
            rs1_data <= rs1_q[i];
            rs2_data <= rs2_q[i];
         end
         else begin
            ena <= 1'b0;
         end
         @(negedge clk); // previous row was taken at this posedge
         if (i > 0) begin
            check_value($sformatf("%s pc", name_q[i-1]), exp_pc_q[i-1], pc);
            check_value($sformatf("%s redirect", name_q[i-1]), exp_redirect_q[i-1], redirect);
         end
      end
      $display("Test passed");
      $finish;
   end

   initial begin
      wait (table_ready);
      #((name_q.size() + reset_cycles + 8) * clk_period);
      $display("timeout: the table did not finish within the expected time");
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule
